/* verilog/portMapPkg.sv */
`default_nettype none

package portMapPkg;

	////////////////////////////////////////////////////////////////////////////
	// Processor port bus types
	////////////////////////////////////////////////////////////////////////////
	typedef logic [7:0] portIdT;		// Port address from the processor
	typedef logic [7:0] portDataT;		// One data byte, either direction

	////////////////////////////////////////////////////////////////////////////
	// Port map. Direction is seen from the processor
	////////////////////////////////////////////////////////////////////////////
	localparam portIdT PA_OOB          = 8'h08;	// (o) Out-of-bounds marker
	localparam portIdT PA_CONN_EST     = 8'h09;	// (i) Link status, rx ready at bit 6
	localparam portIdT PA_CURSOR_CHECK = 8'h0A;	// (o) Cursor and selected read address
	localparam portIdT PA_RAM_W_ADDR   = 8'h0B;	// (o) Write address, fires the write
	localparam portIdT PA_VALID_FLAG   = 8'h0C;	// (i) Placement validity
	localparam portIdT PA_RAM_SELECT   = 8'h13;	// (o) Our board or their board
	localparam portIdT PA_RAM_W_VAL    = 8'h18;	// (o) Cell value to write
	localparam portIdT PA_DATA_RX      = 8'h19;	// (i) Byte from the radio

	// Extra read addresses on our board while a ship is placed
	localparam portIdT PA_SHIP_CHECK_1 = 8'h1A;
	localparam portIdT PA_SHIP_CHECK_2 = 8'h1B;
	localparam portIdT PA_SHIP_CHECK_3 = 8'h1C;
	localparam portIdT PA_SHIP_CHECK_4 = 8'h1D;

	localparam portIdT PA_DATA_TX      = 8'h1E;	// (o) Byte to the radio
	localparam portIdT PA_DATA_RAM     = 8'h1F;	// (i) Read data of the selected board

	// Data values with a fixed meaning
	localparam portDataT OUT_OF_BOUNDS = 8'hFF;	// Overrides the RAM check
	localparam portDataT VALID_FLAG    = 8'h01;
	localparam portDataT INVALID_FLAG  = 8'h00;

endpackage

`default_nettype wire

/* verilog/boardPkg.sv */
`default_nettype none

package boardPkg;

	////////////////////////////////////////////////////////////////////////////
	// Game boards
	////////////////////////////////////////////////////////////////////////////
	localparam int NUM_BOARDS = 2;
	localparam int US_BOARD   = 0;	// Our ship positions
	localparam int THEM_BOARD = 1;	// Our guesses at their ships

	typedef logic boardSelT;		// Board index as carried in the select register

	// One board cell in RAM
	typedef logic [7:0] cellAddrT;	// Cell address
	typedef logic [1:0] cellValT;	// Empty, ship, hit or miss

endpackage

`default_nettype wire

/* verilog/boardRamChannel.sv */
`timescale 1ns/1ps
`default_nettype none

module boardRamChannel
	import portMapPkg::*, boardPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     rdAddrStb,
	input  logic     wrAddrStb,
	input  logic     wrValStb,
	input  portDataT data,
	output cellAddrT readAddr,
	output cellAddrT writeAddr,
	output cellValT  writeVal,
	output logic     writeEn
);

	logic wrPending;	// Write address just landed, fire on the next edge

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			readAddr  <= '0;
			writeAddr <= '0;
			writeVal  <= '0;
			wrPending <= 1'b0;
			writeEn   <= 1'b0;
		end else begin
			if (rdAddrStb)
				readAddr <= data;
			if (wrAddrStb)
				writeAddr <= data;
			if (wrValStb)
				writeVal <= data[$bits(cellValT)-1:0];	// Low bits carry the cell code
			// Value must already be in place when the address arrives
			wrPending <= wrAddrStb;
			writeEn   <= wrPending;	// One-cycle pulse
		end
	end

endmodule

`default_nettype wire

/* verilog/portWriteDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module portWriteDecode
	import portMapPkg::*, boardPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     writeStrobe,
	input  portIdT   portId,
	input  portDataT outPort,
	output logic     rdAddrStb [NUM_BOARDS],
	output logic     wrAddrStb [NUM_BOARDS],
	output logic     wrValStb [NUM_BOARDS],
	output logic     txStb,
	output boardSelT selBoard,
	output portDataT oob,
	output cellAddrT cursor,
	output portDataT txData
);

	logic cursorWr;		// Strobed writes, one per port of interest
	logic shipChkWr;
	logic wrAddrWr;
	logic wrValWr;

	assign cursorWr  = writeStrobe && (portId == PA_CURSOR_CHECK);
	assign wrAddrWr  = writeStrobe && (portId == PA_RAM_W_ADDR);
	assign wrValWr   = writeStrobe && (portId == PA_RAM_W_VAL);
	assign shipChkWr = writeStrobe && (portId inside {PA_SHIP_CHECK_1, PA_SHIP_CHECK_2,
		PA_SHIP_CHECK_3, PA_SHIP_CHECK_4});
	assign txStb     = writeStrobe && (portId == PA_DATA_TX);	// Radio raises txSend

	////////////////////////////////////////////////////////////////////////////
	// Route field strobes to the boards
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int b = 0; b < NUM_BOARDS; b++) begin
			// Cursor check reads the selected board, ship checks always read ours
			rdAddrStb[b] = (cursorWr && (selBoard == boardSelT'(b)))
				|| (shipChkWr && (b == US_BOARD));
			wrAddrStb[b] = wrAddrWr && (selBoard == boardSelT'(b));
			wrValStb[b]  = wrValWr && (selBoard == boardSelT'(b));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Registers held here
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			selBoard <= boardSelT'(US_BOARD);
			oob      <= '0;
			cursor   <= '0;
			txData   <= '0;
		end else if (writeStrobe) begin
			case (portId)
				PA_RAM_SELECT:   selBoard <= outPort[0] ? boardSelT'(THEM_BOARD)
					: boardSelT'(US_BOARD);
				PA_OOB:          oob <= outPort;	// Processor computes the bounds
				PA_CURSOR_CHECK: cursor <= outPort;	// Also the display cursor
				PA_DATA_TX:      txData <= outPort;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/placementCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module placementCheck
	import portMapPkg::*, boardPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  portIdT   portId,
	input  cellValT  readData,
	input  portDataT oob,
	output portDataT validFlag
);

	cellValT accum;		// OR of every cell looked at since the last flag read
	logic    clrArm;	// Flag port was read last cycle

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			accum  <= '0;
			clrArm <= 1'b0;
		end else begin
			clrArm <= (portId == PA_VALID_FLAG);
			if (clrArm)
				accum <= '0;	// Result consumed, start a new check
			else
				accum <= accum | readData;	// Any nonempty cell blocks the ship
		end
	end

	// Out of bounds wins over an empty board
	assign validFlag = ((oob != OUT_OF_BOUNDS) && (accum == '0)) ? VALID_FLAG : INVALID_FLAG;

endmodule

`default_nettype wire

/* verilog/radioLink.sv */
`timescale 1ns/1ps
`default_nettype none

module radioLink
	import portMapPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  portIdT   portId,
	input  logic     rxReady,
	input  portDataT rxData,
	input  logic     txStb,
	output logic     rxHeld,
	output portDataT rxDataLatched,
	output logic     txSend
);

	// Receive byte, kept until the next one arrives
	always_ff @(posedge clk) begin
		if (rxReady)
			rxDataLatched <= rxData;
	end

	////////////////////////////////////////////////////////////////////////////
	// Handshake flags
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rxHeld <= 1'b0;
			txSend <= 1'b0;
		end else begin
			// Held until the processor reads the byte, new arrival wins
			if (rxReady)
				rxHeld <= 1'b1;
			else if (portId == PA_DATA_RX)
				rxHeld <= 1'b0;
			// No busy from the transmitter, so hold until the other side answers
			if (txStb)
				txSend <= 1'b1;
			else if (rxReady)
				txSend <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/portReadMux.sv */
`timescale 1ns/1ps
`default_nettype none

module portReadMux
	import portMapPkg::*, boardPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  portIdT   portId,
	input  boardSelT selBoard,
	input  portDataT oob,
	input  cellAddrT cursor,
	input  portDataT txData,
	input  portDataT validFlag,
	input  logic     rxHeld,
	input  portDataT rxDataLatched,
	input  cellAddrT boardReadAddr [NUM_BOARDS],
	input  cellAddrT boardWriteAddr [NUM_BOARDS],
	input  cellValT  boardWriteVal [NUM_BOARDS],
	input  cellValT  boardReadData [NUM_BOARDS],
	output portDataT inPort
);

	cellAddrT selRdAddr;	// Fields of the selected board
	cellAddrT selWrAddr;
	cellValT  selWrVal;
	cellValT  selRdData;

	assign selRdAddr = boardReadAddr[selBoard];
	assign selWrAddr = boardWriteAddr[selBoard];
	assign selWrVal  = boardWriteVal[selBoard];
	assign selRdData = boardReadData[selBoard];

	////////////////////////////////////////////////////////////////////////////
	// Input port, one cycle behind portId
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			inPort <= '0;
		end else begin
			case (portId)
				PA_OOB:          inPort <= oob;
				PA_CONN_EST:     inPort <= {1'b0, rxHeld, 6'b0};	// Ready flag at bit 6
				PA_CURSOR_CHECK: inPort <= portDataT'(selRdAddr);
				PA_RAM_W_ADDR:   inPort <= portDataT'(selWrAddr);
				PA_VALID_FLAG:   inPort <= validFlag;
				PA_RAM_SELECT:   inPort <= portDataT'(selBoard);
				PA_RAM_W_VAL:    inPort <= portDataT'(selWrVal);
				PA_DATA_RX:      inPort <= rxDataLatched;
				// Ship checks read back the cursor
				PA_SHIP_CHECK_1,
				PA_SHIP_CHECK_2,
				PA_SHIP_CHECK_3,
				PA_SHIP_CHECK_4: inPort <= portDataT'(cursor);
				PA_DATA_TX:      inPort <= txData;
				PA_DATA_RAM:     inPort <= portDataT'(selRdData);
				default:         inPort <= '0;	// Unmapped
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/picoPortIf.sv */
`timescale 1ns/1ps
`default_nettype none

module picoPortIf
	import portMapPkg::*, boardPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	// Processor port bus
	input  portIdT   portId,
	input  portDataT outPort,
	input  logic     writeStrobe,
	output portDataT inPort,
	// Display
	output cellAddrT cursor,
	// Board RAMs
	output cellAddrT boardReadAddr [NUM_BOARDS],
	output cellAddrT boardWriteAddr [NUM_BOARDS],
	output cellValT  boardWriteVal [NUM_BOARDS],
	output logic     boardWriteEn [NUM_BOARDS],
	input  cellValT  boardReadData [NUM_BOARDS],
	// Radio
	input  logic     rxReady,
	input  portDataT rxData,
	output logic     txSend,
	output portDataT txData
);

	logic     rdAddrStb [NUM_BOARDS];	// Per-board field strobes
	logic     wrAddrStb [NUM_BOARDS];
	logic     wrValStb [NUM_BOARDS];
	logic     txStb;
	boardSelT selBoard;
	portDataT oob;
	portDataT validFlag;
	logic     rxHeld;
	portDataT rxDataLatched;

	portWriteDecode uDecode (
		.clk, .rstN, .writeStrobe, .portId, .outPort,
		.rdAddrStb, .wrAddrStb, .wrValStb, .txStb,
		.selBoard, .oob, .cursor, .txData
	);

	// One channel per board, data byte straight from the processor
	for (genvar b = 0; b < NUM_BOARDS; b++) begin : gBoard
		boardRamChannel uChan (
			.clk, .rstN,
			.rdAddrStb(rdAddrStb[b]), .wrAddrStb(wrAddrStb[b]), .wrValStb(wrValStb[b]),
			.data(outPort),
			.readAddr(boardReadAddr[b]), .writeAddr(boardWriteAddr[b]),
			.writeVal(boardWriteVal[b]), .writeEn(boardWriteEn[b])
		);
	end

	placementCheck uCheck (
		.clk, .rstN, .portId,
		.readData(boardReadData[US_BOARD]),	// Only our board holds ships to collide with
		.oob, .validFlag
	);

	radioLink uRadio (.clk, .rstN, .portId, .rxReady, .rxData, .txStb,
		.rxHeld, .rxDataLatched, .txSend);

	portReadMux uReadMux (
		.clk, .rstN, .portId,
		.selBoard, .oob, .cursor, .txData, .validFlag, .rxHeld, .rxDataLatched,
		.boardReadAddr, .boardWriteAddr, .boardWriteVal, .boardReadData,
		.inPort
	);

endmodule

`default_nettype wire

/* dv/picoPortIf_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module picoPortIf_properties (
	input logic clk,
	input logic rstN,
	input logic wrAddrStb,
	input logic writeEn
);

	// Write enable is a single-cycle pulse
	pulseOneCycle: assert property (@(posedge clk) disable iff (!rstN)
		writeEn |=> !writeEn)
		else $error("writeEn high for two cycles in a row");

	////////////////////////////////////////////////////////////////////////////
	// Strobe to enable latency of two edges, checked both ways
	////////////////////////////////////////////////////////////////////////////
	strobeToEnable: assert property (@(posedge clk) disable iff (!rstN)
		wrAddrStb |-> ##2 writeEn)
		else $error("writeEn missing two edges after a write-address strobe");

	enableFromStrobe: assert property (@(posedge clk) disable iff (!rstN)
		writeEn |-> $past(wrAddrStb, 2))	// No spurious writes
		else $error("writeEn without a write-address strobe two edges earlier");

endmodule

bind boardRamChannel picoPortIf_properties uProps (.clk, .rstN, .wrAddrStb, .writeEn);

`default_nettype wire

/* dv/tbPicoPortIf.sv */
`timescale 1ns/1ps
`default_nettype none

module tbPicoPortIf
	import portMapPkg::*, boardPkg::*;
();

	typedef enum logic [2:0] {K_WRITE, K_READ, K_RX, K_RAM, K_CHECK} kindT;
	typedef struct packed {
		kindT     kind;
		portIdT   port;		// Cell address for K_RAM, output code for K_CHECK
		portDataT data;
		portDataT exp;		// Expected byte, or the write value for a write-address step
	} stepT;

	localparam portIdT SIG_CURSOR  = 8'd0;	// Output codes of K_CHECK steps
	localparam portIdT SIG_TXSEND  = 8'd1;
	localparam portIdT SIG_TXDATA  = 8'd2;
	localparam portIdT SIG_RDADDR0 = 8'd3;
	localparam int unsigned SEED   = 32'h2a2b;
	localparam int RESET_CYCLES    = 10;

	logic     clk = 1'b0;
	logic     rstN;
	portIdT   portId;
	portDataT outPort;
	logic     writeStrobe;
	portDataT inPort;
	cellAddrT cursor;
	cellAddrT boardReadAddr [NUM_BOARDS];
	cellAddrT boardWriteAddr [NUM_BOARDS];
	cellValT  boardWriteVal [NUM_BOARDS];
	logic     boardWriteEn [NUM_BOARDS];
	cellValT  boardReadData [NUM_BOARDS];
	logic     rxReady;
	portDataT rxData;
	logic     txSend;
	portDataT txData;

	stepT     steps[$];		// Stimulus table
	boardSelT curSel;		// Board the select register should hold
	int       cycles = 0;
	int       timeoutLimit = 0;	// Zero until the table is built

	picoPortIf uut (
		.clk, .rstN, .portId, .outPort, .writeStrobe, .inPort, .cursor,
		.boardReadAddr, .boardWriteAddr, .boardWriteVal, .boardWriteEn, .boardReadData,
		.rxReady, .rxData, .txSend, .txData
	);

	always #4 clk = ~clk;	// 8 ns period

	////////////////////////////////////////////////////////////////////////////
	// Board RAM model that starts empty
	////////////////////////////////////////////////////////////////////////////
	cellValT  ram [NUM_BOARDS][256] = '{default: '0};
	logic     pokeEn;		// Direct store of ship cells into our board
	cellAddrT pokeAddr;
	cellValT  pokeVal;

	always @(posedge clk) begin
		if (boardWriteEn[US_BOARD])
			ram[US_BOARD][boardWriteAddr[US_BOARD]] <= boardWriteVal[US_BOARD];
		if (boardWriteEn[THEM_BOARD])
			ram[THEM_BOARD][boardWriteAddr[THEM_BOARD]] <= boardWriteVal[THEM_BOARD];
		if (pokeEn)
			ram[US_BOARD][pokeAddr] <= pokeVal;
	end

	always_comb begin
		for (int b = 0; b < NUM_BOARDS; b++)
			boardReadData[b] = ram[b][boardReadAddr[b]];	// Asynchronous read
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (timeoutLimit != 0 && cycles >= timeoutLimit) begin
			$display("Timeout after %0d cycles, the step table did not complete", cycles);
			$display(">>> FAIL");
			$fatal(1, "Simulation timed out");
		end
	end

	task automatic compareValue(input string name, input portDataT got, input portDataT exp);
		if (got !== exp) begin
			$display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			$display(">>> FAIL");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic idleBus();
		portId      = 8'h00;	// Unmapped port without side effects
		outPort     = 8'h00;
		writeStrobe = 1'b0;
		rxReady     = 1'b0;
		rxData      = 8'h00;
		pokeEn      = 1'b0;
	endtask

	task automatic addStep(input kindT kind, input portIdT port, input portDataT data,
		input portDataT exp);
		steps.push_back(stepT'{kind, port, data, exp});
	endtask

	// Enable quiet after edge N+1, pulse after N+2, gone after N+3
	task automatic checkWritePulse(input cellAddrT addr, input portDataT val);
		boardSelT other;
		other = ~curSel;
		compareValue($sformatf("boardWriteEn[%0d]", curSel),
			portDataT'(boardWriteEn[curSel]), 8'h00);
		@(negedge clk);
		compareValue($sformatf("boardWriteEn[%0d]", curSel),
			portDataT'(boardWriteEn[curSel]), 8'h01);
		compareValue($sformatf("boardWriteEn[%0d]", other),
			portDataT'(boardWriteEn[other]), 8'h00);
		compareValue("boardWriteAddr", boardWriteAddr[curSel], addr);
		compareValue("boardWriteVal", portDataT'(boardWriteVal[curSel]), val);
		@(negedge clk);
		compareValue($sformatf("boardWriteEn[%0d]", curSel),
			portDataT'(boardWriteEn[curSel]), 8'h00);
	endtask

	task automatic runStep(input stepT s);
		case (s.kind)
			K_WRITE: begin
				portId      = s.port;
				outPort     = s.data;
				writeStrobe = 1'b1;
				@(negedge clk);
				idleBus();
				if (s.port == PA_RAM_SELECT)
					curSel = s.data[0];
				if (s.port == PA_RAM_W_ADDR)
					checkWritePulse(s.data, s.exp);
			end
			K_READ: begin
				portId = s.port;	// inPort registered at the next edge
				@(negedge clk);
				idleBus();
				compareValue($sformatf("inPort (port 0x%h)", s.port), inPort, s.exp);
			end
			K_RX: begin
				rxReady = 1'b1;
				rxData  = s.data;
				@(negedge clk);
				idleBus();
			end
			K_RAM: begin
				pokeEn   = 1'b1;
				pokeAddr = s.port;
				pokeVal  = s.data[1:0];
				@(negedge clk);
				pokeEn   = 1'b0;
			end
			K_CHECK: begin
				case (s.port)	// Level checks without a clock advance
					SIG_CURSOR: compareValue("cursor", cursor, s.exp);
					SIG_TXSEND: compareValue("txSend", portDataT'(txSend), s.exp);
					SIG_TXDATA: compareValue("txData", txData, s.exp);
					default:    compareValue("boardReadAddr[0]", boardReadAddr[US_BOARD], s.exp);
				endcase
			end
			default: ;
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table with expected values from the port map rules
	////////////////////////////////////////////////////////////////////////////
	task automatic buildTable();
		cellValT  wVal0;
		cellValT  wVal1;
		cellAddrT wAddr0;
		cellAddrT wAddr1;
		cellAddrT cur;
		cellAddrT emptyBase;
		cellAddrT shipBase;
		portDataT txByte;
		portDataT rxByte;
		wVal0     = cellValT'(1 + $urandom % 3);	// Nonzero cell codes
		wVal1     = cellValT'(1 + $urandom % 3);
		wAddr0    = cellAddrT'(8'h80 | $urandom);	// Written cells in the upper half
		wAddr1    = cellAddrT'(8'h80 | $urandom);
		cur       = cellAddrT'($urandom);
		emptyBase = cellAddrT'(8'h20 + $urandom % 28);	// Four cells below 8'h40
		shipBase  = cellAddrT'(8'h40 + $urandom % 60);	// Four cells below 8'h80
		txByte    = portDataT'($urandom);
		rxByte    = portDataT'($urandom);
		// Reset state and unmapped ports
		addStep(K_READ, PA_VALID_FLAG, 8'h00, VALID_FLAG);
		addStep(K_READ, PA_CONN_EST, 8'h00, 8'h00);
		addStep(K_READ, 8'h00, 8'h00, 8'h00);
		// Board write routing to ours and then theirs
		addStep(K_WRITE, PA_RAM_SELECT, 8'h00, 8'h00);
		addStep(K_READ, PA_RAM_SELECT, 8'h00, 8'h00);
		addStep(K_WRITE, PA_RAM_W_VAL, {6'($urandom), wVal0}, 8'h00);	// Upper bits dropped
		addStep(K_READ, PA_RAM_W_VAL, 8'h00, portDataT'(wVal0));
		addStep(K_WRITE, PA_RAM_W_ADDR, wAddr0, portDataT'(wVal0));
		addStep(K_READ, PA_RAM_W_ADDR, 8'h00, wAddr0);
		addStep(K_WRITE, PA_RAM_SELECT, 8'h01, 8'h00);
		addStep(K_READ, PA_RAM_SELECT, 8'h00, 8'h01);
		addStep(K_READ, PA_RAM_W_ADDR, 8'h00, 8'h00);	// Their board still at reset
		addStep(K_WRITE, PA_RAM_W_VAL, {6'($urandom), wVal1}, 8'h00);
		addStep(K_WRITE, PA_RAM_W_ADDR, wAddr1, portDataT'(wVal1));
		addStep(K_READ, PA_RAM_W_VAL, 8'h00, portDataT'(wVal1));
		// Cursor, read addresses and stored RAM data
		addStep(K_WRITE, PA_CURSOR_CHECK, wAddr1, 8'h00);
		addStep(K_READ, PA_CURSOR_CHECK, 8'h00, wAddr1);
		addStep(K_READ, PA_DATA_RAM, 8'h00, portDataT'(wVal1));
		addStep(K_WRITE, PA_CURSOR_CHECK, cur, 8'h00);
		addStep(K_CHECK, SIG_CURSOR, 8'h00, cur);
		addStep(K_CHECK, SIG_RDADDR0, 8'h00, 8'h00);
		addStep(K_READ, PA_CURSOR_CHECK, 8'h00, cur);
		// Ship checks over empty cells hit our board only
		for (int i = 0; i < 4; i++)
			addStep(K_WRITE, portIdT'(PA_SHIP_CHECK_1 + i), portDataT'(emptyBase + i), 8'h00);
		addStep(K_CHECK, SIG_RDADDR0, 8'h00, portDataT'(emptyBase + 3));
		addStep(K_READ, PA_CURSOR_CHECK, 8'h00, cur);
		addStep(K_READ, PA_SHIP_CHECK_2, 8'h00, cur);
		addStep(K_READ, PA_VALID_FLAG, 8'h00, VALID_FLAG);
		// One ship under the third checked cell
		addStep(K_RAM, portIdT'(shipBase + 2), 8'h01, 8'h00);
		for (int i = 0; i < 4; i++)
			addStep(K_WRITE, portIdT'(PA_SHIP_CHECK_1 + i), portDataT'(shipBase + i), 8'h00);
		addStep(K_READ, PA_VALID_FLAG, 8'h00, INVALID_FLAG);
		addStep(K_WRITE, PA_OOB, OUT_OF_BOUNDS, 8'h00);	// Clear lands here
		addStep(K_READ, PA_OOB, 8'h00, OUT_OF_BOUNDS);
		addStep(K_READ, PA_VALID_FLAG, 8'h00, INVALID_FLAG);	// Forced by out of bounds
		addStep(K_WRITE, PA_OOB, 8'h00, 8'h00);
		addStep(K_READ, PA_VALID_FLAG, 8'h00, VALID_FLAG);
		// Radio link
		addStep(K_CHECK, SIG_TXSEND, 8'h00, 8'h00);
		addStep(K_WRITE, PA_DATA_TX, txByte, 8'h00);
		addStep(K_CHECK, SIG_TXSEND, 8'h00, 8'h01);
		addStep(K_CHECK, SIG_TXDATA, 8'h00, txByte);
		addStep(K_READ, PA_DATA_TX, 8'h00, txByte);
		addStep(K_READ, PA_CONN_EST, 8'h00, 8'h00);
		addStep(K_RX, 8'h00, rxByte, 8'h00);
		addStep(K_CHECK, SIG_TXSEND, 8'h00, 8'h00);	// Answer drops the request
		addStep(K_READ, PA_CONN_EST, 8'h00, 8'h40);
		addStep(K_READ, 8'hFF, 8'h00, 8'h00);	// Unmapped read right after a nonzero byte
		addStep(K_READ, PA_CONN_EST, 8'h00, 8'h40);	// Held until read
		addStep(K_READ, PA_DATA_RX, 8'h00, rxByte);
		addStep(K_READ, PA_CONN_EST, 8'h00, 8'h00);
	endtask

	initial begin
		void'($urandom(SEED));
		rstN     = 1'b0;
		idleBus();
		pokeAddr = '0;
		pokeVal  = '0;
		curSel   = boardSelT'(US_BOARD);
		buildTable();
		timeoutLimit = steps.size() * 4 + RESET_CYCLES + 20;
		repeat (RESET_CYCLES) @(negedge clk);
		rstN = 1'b1;
		foreach (steps[i])
			runStep(steps[i]);
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
verilog/portMapPkg.sv
verilog/boardPkg.sv
verilog/boardRamChannel.sv
verilog/portWriteDecode.sv
verilog/placementCheck.sv
verilog/radioLink.sv
verilog/portReadMux.sv
verilog/picoPortIf.sv
dv/picoPortIf_properties.sv
dv/tbPicoPortIf.sv

/* Makefile */
# Verilator simulation of the processor port interface

VERILATOR ?= verilator
TOP       ?= tbPicoPortIf
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) && echo "Test passed" || \
		(echo "Test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
